// File: biu_pkg.sv
// BIU package with bus transfer types and the slave memory map
package biu_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  localparam int XLEN   = 32;
  // Address MSB set marks the non-cacheable IO region
  localparam int ADDR_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [XLEN-1:0]   data_t;
  typedef logic [XLEN/8-1:0] be_t;
  typedef logic [1:0]        prv_t;

  // User privilege level
  localparam prv_t PRV_U = 2'd0;

  //////////////////////////////
  // Slave memory map
  //////////////////////////////

  localparam int RAM_WORDS   = 256;
  localparam int RAM_AW      = $clog2(RAM_WORDS);
  localparam int IO_REGS     = 4;
  localparam int IO_AW       = $clog2(IO_REGS);
  // IO read latency counted from bus acceptance
  localparam int IO_RD_DELAY = 3;
  localparam int IO_CNT_W    = $clog2(IO_RD_DELAY + 1);

  typedef logic [IO_CNT_W-1:0] io_cnt_t;

endpackage

// File: dmem_pkg.sv
// Data memory controller package with FSM states and the pending write count
package dmem_pkg;

  //////////////////////////////
  // Controller FSM
  //////////////////////////////

  // Sparse encoding, READ sits on its own bit
  typedef enum logic [2:0] {
    IDLE     = 3'h0,
    WRITE    = 3'h1,
    WAIT4ACK = 3'h2,
    READ     = 3'h4
  } dmem_state_t;

  //////////////////////////////
  // Posted writes
  //////////////////////////////

  // Enough for the few writes that can be in flight at once
  localparam int PEND_W = 2;

  typedef logic [PEND_W-1:0] pend_cnt_t;

endpackage

// File: dmem_req_if.sv
// Load/store request bundle between the CPU port, the request holder and the controller
interface dmem_req_if
  import biu_pkg::*;
();

  // Strobe for one access, a single-cycle pulse
  logic  req;
  // Store when set, load otherwise
  logic  we;
  addr_t adr;
  // Store data
  data_t d;
  be_t   be;

  // Request holder sees the full live request
  modport holder (
    input req,
    input we,
    input adr,
    input d,
    input be
  );

  // Controller only needs the live strobe
  modport ctrl (
    input req
  );

endinterface

// File: dmem_req_hold.sv
// Request holder that keeps an unaccepted access and muxes held or live fields onto the bus
module dmem_req_hold
  import biu_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  dmem_req_if.holder        req_if,
  input  logic              biu_stb_ack,
  output logic              hold_req,
  output addr_t             adr,
  output data_t             di,
  output logic              we,
  output be_t               be
);

  logic  hold_we;
  addr_t hold_adr;
  data_t hold_d;
  be_t   hold_be;

  // Snapshot every new request
  always_ff @(posedge clk)
  begin
    if (req_if.req)
    begin
      hold_we  <= req_if.we;
      hold_adr <= req_if.adr;
      hold_d   <= req_if.d;
      hold_be  <= req_if.be;
    end
  end

  // Pending until the slave takes it
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      hold_req <= 1'b0;
    else
      hold_req <= (req_if.req | hold_req) & ~biu_stb_ack;
  end

  // Live fields pass straight through on the request cycle
  assign adr = hold_req ? hold_adr : req_if.adr;
  assign di  = hold_req ? hold_d   : req_if.d;
  assign we  = hold_req ? hold_we  : req_if.we;
  assign be  = hold_req ? hold_be  : req_if.be;

  // CPU waits for mem_ack, so a held access is never overrun
  no_req_while_held_a: assert property (@(posedge clk) disable iff (!rstn)
    req_if.req |-> !hold_req)
    else $error("new request while previous one still held");

endmodule

// File: dmem_wr_pending.sv
// Counter of posted writes still waiting for their bus write acknowledge
module dmem_wr_pending
  import dmem_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      wr_issue,
  input  logic      wr_done,
  output pend_cnt_t cnt
);

  //////////////////////////////
  // Count update
  //////////////////////////////

  // Issue and acknowledge in one cycle leave the count as is
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      cnt <= '0;
    else if (wr_issue && !wr_done)
      cnt <= cnt + 1'b1;
    else if (wr_done && !wr_issue && cnt != '0)
      cnt <= cnt - 1'b1;
  end

  // More posted writes than the counter can track
  no_overflow_a: assert property (@(posedge clk) disable iff (!rstn)
    (wr_issue && !wr_done) |-> cnt != '1)
    else $error("pending write counter overflow");

endmodule

// File: dmem_nocache_ctrl.sv
// No-cache data memory controller FSM issuing bus strobes and returning CPU acks and load data
module dmem_nocache_ctrl
  import biu_pkg::*, dmem_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  dmem_req_if.ctrl    req_if,
  input  logic        hold_req,
  input  logic        sel_we,
  input  logic        biu_stb_ack,
  input  logic        biu_wack,
  input  logic        biu_rack,
  input  data_t       biu_do,
  input  pend_cnt_t   pend_cnt,
  output logic        biu_stb,
  output logic        wr_issue,
  output data_t       mem_q,
  output logic        mem_ack
);

  dmem_state_t state;
  logic        req_any;
  logic        wr_drained;
  logic        accept;

  //////////////////////////////
  // Request decode
  //////////////////////////////

  // Live pulse or an access parked in the holder
  assign req_any = req_if.req | hold_req;

  // No posted write left once this cycle's wack is counted
  assign wr_drained = (pend_cnt == '0) |
                      ((pend_cnt == pend_cnt_t'(1)) & biu_wack);

  //////////////////////////////
  // Bus strobe
  //////////////////////////////

  always_comb
  begin
    case (state)
      IDLE:
        biu_stb = req_any;
      // Loads hold back until every posted store is acknowledged
      WRITE, WAIT4ACK:
        biu_stb = req_any & (sel_we | wr_drained);
      // Loads block, nothing new can arrive here
      default:
        biu_stb = 1'b0;
    endcase
  end

  assign accept   = biu_stb & biu_stb_ack;
  assign wr_issue = accept & sel_we;

  //////////////////////////////
  // State machine
  //////////////////////////////

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state   <= IDLE;
      mem_ack <= 1'b0;
    end
    else
    begin
      // Stores ack on acceptance, loads on returning data
      mem_ack <= wr_issue | biu_rack;

      case (state)
        IDLE:
        begin
          if (accept)
            state <= sel_we ? WRITE : READ;
        end

        WRITE:
        begin
          if (accept)
            state <= sel_we ? WRITE : READ;
          else if (req_any && !sel_we)
            state <= WAIT4ACK;
          // Back to IDLE only with all stores done
          else if (!req_any && wr_drained)
            state <= IDLE;
        end

        // Load parked in holder until the last wack
        WAIT4ACK:
        begin
          if (accept)
            state <= READ;
        end

        READ:
        begin
          if (biu_rack)
            state <= IDLE;
        end

        default:
          state <= IDLE;
      endcase
    end
  end

  // Load data register
  always_ff @(posedge clk)
  begin
    if (state == READ && biu_rack)
      mem_q <= biu_do;
  end

  // Slave only answers a load that this FSM is waiting for
  rack_in_read_a: assert property (@(posedge clk) disable iff (!rstn)
    biu_rack |-> state == READ)
    else $error("biu_rack received outside READ state");

endmodule

// File: biu_sram.sv
// BIU slave model with a byte-enabled RAM region and a slow IO register bank
module biu_sram
  import biu_pkg::*;
(
  input  logic  clk,
  input  logic  rstn,
  input  logic  stb,
  input  logic  we,
  input  addr_t adr,
  input  data_t di,
  input  be_t   be,
  input  logic  is_cacheable,
  input  prv_t  prv,
  output logic  stb_ack,
  output logic  wack,
  output logic  rack,
  output data_t dout
);

  // RAM comes up cleared
  data_t             ram [RAM_WORDS] = '{default: '0};
  data_t             io_reg [IO_REGS];
  logic              accept;
  logic              rd_busy;
  logic [RAM_AW-1:0] ram_idx;
  logic [IO_AW-1:0]  io_idx;
  logic [IO_AW-1:0]  io_rd_idx;
  io_cnt_t           io_cnt;

  //////////////////////////////
  // Acceptance
  //////////////////////////////

  // One outstanding load at a time
  assign stb_ack = stb & ~rd_busy;
  assign accept  = stb & stb_ack;
  assign ram_idx = adr[RAM_AW+1:2];
  assign io_idx  = adr[IO_AW+1:2];

  // RAM write with byte lanes
  always_ff @(posedge clk)
  begin
    if (accept && we && is_cacheable)
      for (int b = 0; b < XLEN/8; b++)
        if (be[b])
          ram[ram_idx][8*b +: 8] <= di[8*b +: 8];
  end

  // IO write, user-mode stores silently dropped
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      for (int i = 0; i < IO_REGS; i++)
        io_reg[i] <= '0;
    else if (accept && we && !is_cacheable && prv != PRV_U)
      for (int b = 0; b < XLEN/8; b++)
        if (be[b])
          io_reg[io_idx][8*b +: 8] <= di[8*b +: 8];
  end

  //////////////////////////////
  // Responses
  //////////////////////////////

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wack    <= 1'b0;
      rack    <= 1'b0;
      rd_busy <= 1'b0;
      io_cnt  <= '0;
    end
    else
    begin
      // Every accepted store acks next cycle, dropped ones too
      wack <= accept & we;
      rack <= (accept & ~we & is_cacheable) | (io_cnt == io_cnt_t'(1));

      // IO load countdown, rack follows the last step
      if (accept && !we && !is_cacheable)
        io_cnt <= io_cnt_t'(IO_RD_DELAY - 1);
      else if (io_cnt != '0)
        io_cnt <= io_cnt - 1'b1;

      if (accept && !we)
        rd_busy <= 1'b1;
      else if (rack)
        rd_busy <= 1'b0;
    end
  end

  // Read data path
  always_ff @(posedge clk)
  begin
    if (accept && !we && !is_cacheable)
      io_rd_idx <= io_idx;

    if (accept && !we && is_cacheable)
      dout <= ram[ram_idx];
    else if (io_cnt == io_cnt_t'(1))
      dout <= io_reg[io_rd_idx];
  end

endmodule

// File: dmem_subsys_top.sv
// Data memory subsystem top joining the no-cache controller, its datapath and the BIU slave
module dmem_subsys_top
  import biu_pkg::*, dmem_pkg::*;
(
  input  logic  clk,
  input  logic  rstn,
  input  addr_t mem_adr,
  input  data_t mem_d,
  input  logic  mem_req,
  input  logic  mem_we,
  input  be_t   mem_be,
  input  prv_t  st_prv,
  output data_t mem_q,
  output logic  mem_ack
);

  logic      hold_req;
  logic      wr_issue;
  pend_cnt_t pend_cnt;

  // Bus wires
  logic      biu_stb;
  logic      biu_stb_ack;
  logic      biu_wack;
  logic      biu_rack;
  data_t     biu_do;
  addr_t     biu_adr;
  data_t     biu_di;
  logic      biu_we;
  be_t       biu_be;
  logic      biu_is_cacheable;
  prv_t      biu_prv;

  //////////////////////////////
  // CPU request bundle
  //////////////////////////////

  dmem_req_if req_if ();

  assign req_if.req = mem_req;
  assign req_if.we  = mem_we;
  assign req_if.adr = mem_adr;
  assign req_if.d   = mem_d;
  assign req_if.be  = mem_be;

  dmem_req_hold dmem_req_hold_inst (
    .clk         (clk),
    .rstn        (rstn),
    .req_if      (req_if),
    .biu_stb_ack (biu_stb_ack),
    .hold_req    (hold_req),
    .adr         (biu_adr),
    .di          (biu_di),
    .we          (biu_we),
    .be          (biu_be)
  );

  dmem_wr_pending dmem_wr_pending_inst (
    .clk      (clk),
    .rstn     (rstn),
    .wr_issue (wr_issue),
    .wr_done  (biu_wack),
    .cnt      (pend_cnt)
  );

  dmem_nocache_ctrl dmem_nocache_ctrl_inst (
    .clk         (clk),
    .rstn        (rstn),
    .req_if      (req_if),
    .hold_req    (hold_req),
    .sel_we      (biu_we),
    .biu_stb_ack (biu_stb_ack),
    .biu_wack    (biu_wack),
    .biu_rack    (biu_rack),
    .biu_do      (biu_do),
    .pend_cnt    (pend_cnt),
    .biu_stb     (biu_stb),
    .wr_issue    (wr_issue),
    .mem_q       (mem_q),
    .mem_ack     (mem_ack)
  );

  // MSB clear selects the cacheable region
  assign biu_is_cacheable = ~biu_adr[ADDR_W-1];
  assign biu_prv          = st_prv;

  biu_sram biu_sram_inst (
    .clk          (clk),
    .rstn         (rstn),
    .stb          (biu_stb),
    .we           (biu_we),
    .adr          (biu_adr),
    .di           (biu_di),
    .be           (biu_be),
    .is_cacheable (biu_is_cacheable),
    .prv          (biu_prv),
    .stb_ack      (biu_stb_ack),
    .wack         (biu_wack),
    .rack         (biu_rack),
    .dout         (biu_do)
  );

endmodule

// File: tb_dmem_subsys.sv
// Testbench for the data memory subsystem with LFSR stimulus, reference model and read checks
module tb_dmem_subsys
  import biu_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int   CLK_PERIOD = 100;
  localparam int   RST_CYCLES = 4;
  localparam prv_t PRV_M      = 2'd3;
  // Request count is 3 single + 24 byte enable + 5 posted + 8 IO + 4 privilege + 200 random
  localparam int   N_REQ          = 244;
  localparam int   TIMEOUT_CYCLES = RST_CYCLES + 20 * N_REQ;

  logic  clk;
  logic  rstn;
  addr_t mem_adr;
  data_t mem_d;
  logic  mem_req;
  logic  mem_we;
  be_t   mem_be;
  prv_t  st_prv;
  data_t mem_q;
  logic  mem_ack;

  logic [31:0] lfsr = 32'h1932_f01d;
  int          cycle_cnt = 0;
  // Shadow copies of both slave regions
  data_t       ram_ref [RAM_WORDS] = '{default: '0};
  data_t       io_ref [IO_REGS] = '{default: '0};
  // Outstanding accesses in issue order
  data_t       exp_q [$];
  logic        rd_q [$];
  string       name_q [$];
  data_t       chk_exp;
  logic        chk_rd;
  string       chk_name;

  dmem_subsys_top dmem_subsys_top_inst (
    .clk     (clk),
    .rstn    (rstn),
    .mem_adr (mem_adr),
    .mem_d   (mem_d),
    .mem_req (mem_req),
    .mem_we  (mem_we),
    .mem_be  (mem_be),
    .st_prv  (st_prv),
    .mem_q   (mem_q),
    .mem_ack (mem_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Galois LFSR stepped once per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        lsb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lsb  = lfsr[0];
      lfsr = {1'b0, lfsr[31:1]} ^ (lsb ? 32'h8020_0003 : 32'h0);
      v    = {v[30:0], lsb};
    end
    return v;
  endfunction

  // Word aligned RAM address with the MSB clear
  function automatic addr_t ram_addr();
    return addr_t'(rand_bits(8)) << 2;
  endfunction

  // Word aligned IO address with the MSB set
  function automatic addr_t io_addr();
    return 32'h8000_0000 | (addr_t'(rand_bits(2)) << 2);
  endfunction

  // Applies one access to the shadow state and returns the word a read sees
  function automatic data_t ref_access(input logic we, input addr_t adr, input data_t d,
                                       input be_t be, input prv_t prv);
    data_t word;
    logic  io;
    io   = adr[ADDR_W-1];
    word = io ? io_ref[adr[3:2]] : ram_ref[adr[9:2]];
    // User stores into IO are dropped
    if (we && !(io && prv == PRV_U))
    begin
      for (int b = 0; b < 4; b++)
        if (be[b])
          word[8*b +: 8] = d[8*b +: 8];
      if (io)
        io_ref[adr[3:2]] = word;
      else
        ram_ref[adr[9:2]] = word;
    end
    return word;
  endfunction

  task automatic check_eq(input string name, input data_t expected, input data_t actual);
    if (expected !== actual)
    begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  // One CPU access that returns on the falling edge where mem_ack is seen
  task automatic cpu_access(input string name, input logic we, input addr_t adr,
                            input data_t d, input be_t be, input prv_t prv);
    exp_q.push_back(ref_access(we, adr, d, be, prv));
    rd_q.push_back(!we);
    name_q.push_back(name);
    mem_req = 1'b1;
    mem_we  = we;
    mem_adr = adr;
    mem_d   = d;
    mem_be  = be;
    st_prv  = prv;
    @(negedge clk);
    mem_req = 1'b0;
    while (!mem_ack)
      @(negedge clk);
  endtask

  task automatic random_mix(input int n);
    logic  we;
    addr_t adr;
    data_t d;
    be_t   be;
    prv_t  prv;
    for (int i = 0; i < n; i++)
    begin
      we  = rand_bits(1) != '0;
      adr = (rand_bits(1) != '0) ? io_addr() : ram_addr();
      d   = rand_bits(32);
      be  = be_t'(rand_bits(4));
      prv = prv_t'(rand_bits(2));
      cpu_access("random_mix", we, adr, d, be, prv);
    end
  endtask

  //////////////////////////////
  // Checks and timeout
  //////////////////////////////

  // Loads compared when their mem_ack shows up
  always @(negedge clk)
  begin
    if (rstn && mem_ack)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Acknowledge arrived with no request outstanding");
        $display("TESTBENCH FAILED");
        $fatal(1);
      end
      else
      begin
        chk_exp  = exp_q.pop_front();
        chk_rd   = rd_q.pop_front();
        chk_name = name_q.pop_front();
        if (chk_rd)
          check_eq(chk_name, chk_exp, mem_q);
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, no acknowledge arrived", cycle_cnt);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial
  begin
    rstn    = 1'b0;
    mem_req = 1'b0;
    mem_we  = 1'b0;
    mem_adr = '0;
    mem_d   = '0;
    mem_be  = '0;
    st_prv  = PRV_M;
    repeat (RST_CYCLES) @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);

    // Single write and read followed by untouched RAM
    cpu_access("ram_write_read", 1'b1, 32'h0000_0010, rand_bits(32), 4'hf, PRV_M);
    cpu_access("ram_write_read", 1'b0, 32'h0000_0010, '0, 4'hf, PRV_M);
    cpu_access("ram_unwritten", 1'b0, 32'h0000_03f0, '0, 4'hf, PRV_M);

    // Partial stores merge with old contents
    for (int i = 0; i < 8; i++)
    begin
      mem_adr = ram_addr();
      cpu_access("byte_enable", 1'b1, mem_adr, rand_bits(32), 4'hf, PRV_M);
      cpu_access("byte_enable", 1'b1, mem_adr, rand_bits(32), be_t'(rand_bits(4)), PRV_M);
      cpu_access("byte_enable", 1'b0, mem_adr, '0, 4'hf, PRV_M);
    end

    // Posted stores back to back so the load has to wait for the last wack
    for (int i = 0; i < 4; i++)
      cpu_access("posted_writes", 1'b1, 32'h0000_0200 + 4 * i, rand_bits(32), 4'hf, PRV_M);
    cpu_access("posted_writes", 1'b0, 32'h0000_0200, '0, 4'hf, PRV_M);

    // IO bank round trip at machine level
    for (int i = 0; i < 4; i++)
      cpu_access("io_machine", 1'b1, 32'h8000_0000 + 4 * i, rand_bits(32), 4'hf, PRV_M);
    for (int i = 0; i < 4; i++)
      cpu_access("io_machine", 1'b0, 32'h8000_0000 + 4 * i, '0, 4'hf, PRV_M);

    // User stores hit RAM but not IO
    cpu_access("user_priv", 1'b1, 32'h8000_0004, rand_bits(32), 4'hf, PRV_U);
    cpu_access("user_priv", 1'b0, 32'h8000_0004, '0, 4'hf, PRV_M);
    cpu_access("user_priv", 1'b1, 32'h0000_0080, rand_bits(32), 4'hf, PRV_U);
    cpu_access("user_priv", 1'b0, 32'h0000_0080, '0, 4'hf, PRV_M);

    random_mix(200);

    // Idle long enough for a stray late acknowledge to reach the checker
    repeat (IO_RD_DELAY + 2) @(negedge clk);
    @(posedge clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: flist.f
biu_pkg.sv
dmem_pkg.sv
dmem_req_if.sv
dmem_req_hold.sv
dmem_wr_pending.sv
dmem_nocache_ctrl.sv
biu_sram.sv
dmem_subsys_top.sv
tb_dmem_subsys.sv
